// File: img_capture_stim.txt
# name skip hdr0 hdr1 hdr2 hdr3 lines pixels_per_line mode expected_words
# skip and geometry in decimal, header words in hex, mode is ramp, ones, zeros or random
ramp_basic     0 a5a5 0001 1234 beef  4  8 ramp   38
ones_grid      0 0001 0002 0003 0004  8  8 ones   70
zeros_grid     0 ffff 0000 8000 7fff  8 12 zeros  102
random_grid    0 c0de 0bad f00d 1357  9 13 random 123
skip_one       1 1111 2222 3333 4444  4  8 ramp   38
skip_two       2 dead beef cafe 0042  5  6 ramp   36
random_skip    1 0f0f f0f0 00ff ff00 12 16 random 198
single_pixel   0 0102 0304 0506 0708  1  1 ramp   7
ones_skip      2 1357 2468 9abc def0  5  9 ones   51
checksum_wrap  0 ffff ffff ffff ffff  6 10 ones   66
random_skip3   3 7777 8888 9999 aaaa  7  4 random 34
long_line      0 0000 0000 0000 0001  2 40 ramp   86

// File: list.f
+incdir+.
img_pkg.sv
frame_timing.sv
fletcher_checksum.sv
capture_sequencer.sv
capture_stats.sv
img_capture.sv
img_capture_tb.sv

// File: img_capture_tb.sv
`include "img_cfg.svh"

module img_capture_tb;
    import img_pkg::*;

    localparam int MAX_TESTS = 32;
    localparam int MAX_PIX   = 1024;
    localparam int HDR_BITS  = `IMG_HEADER_WORDS * `IMG_WORD_WIDTH;

    logic        clk;
    logic        readout_rst;
    logic        capture_start;
    skip_t       skip_count;
    header_t     header;
    logic        img_fv;
    logic        img_lv;
    pixel_t      img_d;
    logic        word_valid;
    img_word_t   word_data;
    logic        capture_done;
    word_count_t word_count;
    stat_count_t highlight_count;
    stat_count_t shadow_count;

    // Test table loaded from the stim file
    string       t_name [MAX_TESTS];
    string       t_mode [MAX_TESTS];
    header_t     t_header [MAX_TESTS];
    int          t_skip [MAX_TESTS];
    int          t_lines [MAX_TESTS];
    int          t_ppl [MAX_TESTS];
    int          t_words [MAX_TESTS];
    int          num_tests;

    integer      seed = 32'h54b5008a;
    int          cycle = 0;
    int          total_cycles = 0;
    int          limit_cycles = 0;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    string       cur_test;
    bit          loaded;

    pixel_t      cap_pix [MAX_PIX];
    img_word_t   exp_words [$];
    img_word_t   got_words [$];
    int          got_edges [$];
    int          exp_high;
    int          exp_shadow;
    int          done_count = 0;
    int          done_words;
    int          done_high;
    int          done_shadow;

    img_capture dut0 (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .capture_start   (capture_start),
        .skip_count      (skip_count),
        .header          (header),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .img_d           (img_d),
        .word_valid      (word_valid),
        .word_data       (word_data),
        .capture_done    (capture_done),
        .word_count      (word_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Output monitor, sampled mid-cycle with the edge that sees the word
    always @(negedge clk) begin
        if (readout_rst) begin
            if (word_valid) begin
                got_words.push_back(word_data);
                got_edges.push_back(cycle + 1);
            end
            if (capture_done) begin
                done_count  = done_count + 1;
                done_words  = word_count;
                done_high   = highlight_count;
                done_shadow = shadow_count;
            end
        end
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles waiting for capture_done", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare_value(input string what, input int expected, input int actual);
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
        end
    endtask

    function automatic img_word_t swap_bytes(input img_word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    function automatic img_word_t pack_pixel(input pixel_t p);
        return {p[7:0], 4'b0000, p[11:8]};
    endfunction

    // Skipped frames carry a ramp that differs per frame
    function automatic pixel_t skip_pixel(input int frame, input int idx);
        return pixel_t'(idx * 3 + 'h300 * (frame + 1));
    endfunction

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          n;
        int          skip;
        int          lines;
        int          ppl;
        int          words;
        string       text;
        string       name;
        string       mode;
        logic [15:0] h0, h1, h2, h3;
        num_tests = 0;
        fd = $fopen("img_capture_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                n = $fgets(text, fd);
                if (n > 0 && text.getc(0) != "#") begin
                    n = $sscanf(text, "%s %d %h %h %h %h %d %d %s %d", name, skip,
                                h0, h1, h2, h3, lines, ppl, mode, words);
                    if (n == 10) begin
                        t_name[num_tests]   = name;
                        t_skip[num_tests]   = skip;
                        t_header[num_tests] = {h0, h1, h2, h3};
                        t_lines[num_tests]  = lines;
                        t_ppl[num_tests]    = ppl;
                        t_mode[num_tests]   = mode;
                        t_words[num_tests]  = words;
                        num_tests = num_tests + 1;
                    end
                end
            end
            $fclose(fd);
            ok = (num_tests > 0);
        end
    endtask

    // ====================
    // Reference model
    // ====================
    task automatic build_expected(input int t);
        int     sum_lo;
        int     sum_hi;
        int     idx;
        pixel_t p;
        exp_words.delete();
        exp_high   = 0;
        exp_shadow = 0;
        for (int k = 0; k < `IMG_HEADER_WORDS; k++) begin
            exp_words.push_back(t_header[t][HDR_BITS-1 - 16*k -: 16]);
        end
        for (int l = 0; l < t_lines[t]; l++) begin
            for (int c = 0; c < t_ppl[t]; c++) begin
                idx = l * t_ppl[t] + c;
                p   = (t_mode[t] == "ones") ? '1 : (t_mode[t] == "zeros") ? '0 :
                      (t_mode[t] == "random") ? pixel_t'($random(seed)) : pixel_t'(idx);
                cap_pix[idx] = p;
                exp_words.push_back(pack_pixel(p));
                // Sample grid of every 4th pixel on every 4th line
                if (l % 4 == 0 && c % 4 == 0) begin
                    if (p[`IMG_PIXEL_WIDTH-1 -: `IMG_STAT_TOP_BITS] == '1) begin
                        exp_high = exp_high + 1;
                    end else if (p[`IMG_PIXEL_WIDTH-1 -: `IMG_STAT_TOP_BITS] == '0) begin
                        exp_shadow = exp_shadow + 1;
                    end
                end
            end
        end
        sum_lo = 0;
        sum_hi = 0;
        foreach (exp_words[i]) begin
            sum_lo = (sum_lo + swap_bytes(exp_words[i])) % 65535;
            sum_hi = (sum_hi + sum_lo) % 65535;
        end
        exp_words.push_back(swap_bytes(img_word_t'(sum_lo)));
        exp_words.push_back(swap_bytes(img_word_t'(sum_hi)));
    endtask

    // Entered and left on a falling edge
    task automatic drive_frame(input int t, input int frame, input bit captured);
        int idx;
        img_fv = 1'b1;
        repeat (6) @(negedge clk);
        for (int l = 0; l < t_lines[t]; l++) begin
            for (int c = 0; c < t_ppl[t]; c++) begin
                idx    = l * t_ppl[t] + c;
                img_lv = 1'b1;
                img_d  = captured ? cap_pix[idx] : skip_pixel(frame, idx);
                @(negedge clk);
            end
            img_lv = 1'b0;
            img_d  = '0;
            repeat (6) @(negedge clk);
        end
        img_fv = 1'b0;
        repeat (6) @(negedge clk);
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int start_edge;
        errs_before = error_count;
        cur_test    = t_name[t];
        build_expected(t);
        got_words.delete();
        got_edges.delete();
        done_count    = 0;
        capture_start = 1'b1;
        skip_count    = skip_t'(t_skip[t]);
        header        = t_header[t];
        start_edge    = cycle + 1;
        @(negedge clk);
        capture_start = 1'b0;
        header        = ~t_header[t];
        repeat (10) @(negedge clk);
        // Stray start while the capture waits for its frame
        capture_start = 1'b1;
        skip_count    = '0;
        @(negedge clk);
        capture_start = 1'b0;
        for (int f = 0; f <= t_skip[t]; f++) begin
            drive_frame(t, f, f == t_skip[t]);
        end
        while (done_count == 0) @(negedge clk);
        repeat (10) @(negedge clk);

        compare_value("capture_done pulses", 1, done_count);
        compare_value("word total", exp_words.size(), got_words.size());
        for (int i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
            compare_value($sformatf("word %0d", i), exp_words[i], got_words[i]);
        end
        for (int k = 0; k < `IMG_HEADER_WORDS && k < got_edges.size(); k++) begin
            compare_value($sformatf("header %0d edge", k), start_edge + 2 + k, got_edges[k]);
        end
        compare_value("word_count", t_words[t], done_words);
        compare_value("highlight_count", exp_high, done_high);
        compare_value("shadow_count", exp_shadow, done_shadow);
        if (error_count == errs_before) begin
            pass_count = pass_count + 1;
            $display("%-14s ok, %0d words", cur_test, got_words.size());
        end else begin
            fail_count = fail_count + 1;
            $display("%-14s %0d mismatches", cur_test, error_count - errs_before);
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        clk           = 1'b0;
        readout_rst   = 1'b0;
        capture_start = 1'b0;
        skip_count    = '0;
        header        = '0;
        img_fv        = 1'b0;
        img_lv        = 1'b0;
        img_d         = '0;
        load_stimulus(loaded);
        if (!loaded) begin
            error_count = error_count + 1;
            $display("ERROR: no tests could be read from img_capture_stim.txt");
        end else begin
            // Frame lengths of all tests, times 4, plus margin
            total_cycles = 0;
            for (int t = 0; t < num_tests; t++) begin
                total_cycles += (t_skip[t] + 1) * (18 + t_lines[t] * (t_ppl[t] + 6)) + 40;
            end
            limit_cycles = total_cycles * 4 + 1000;
            repeat (8) @(negedge clk);
            readout_rst = 1'b1;
            cur_test = "reset";
            compare_value("word_valid", 0, word_valid);
            compare_value("capture_done", 0, capture_done);
            compare_value("word_count", 0, word_count);
            compare_value("highlight_count", 0, highlight_count);
            compare_value("shadow_count", 0, shadow_count);
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: img_capture.sv
module img_capture (
    input  logic                 clk,
    input  logic                 readout_rst,
    input  logic                 capture_start,
    input  img_pkg::skip_t       skip_count,
    input  img_pkg::header_t     header,
    input  logic                 img_fv,
    input  logic                 img_lv,
    input  img_pkg::pixel_t      img_d,
    output logic                 word_valid,
    output img_pkg::img_word_t   word_data,
    output logic                 capture_done,
    output img_pkg::word_count_t word_count,
    output img_pkg::stat_count_t highlight_count,
    output img_pkg::stat_count_t shadow_count
);
    import img_pkg::*;

    pixel_t pix_data;
    logic   line_active;
    logic   frame_active;
    logic   frame_start;
    logic   stat_sample;
    logic   capture_begin;
    logic   capture_frame;
    logic   capture_end;

    // ====================
    // Video decode
    // ====================
    frame_timing u_timing (
        .clk          (clk),
        .readout_rst  (readout_rst),
        .img_fv       (img_fv),
        .img_lv       (img_lv),
        .img_d        (img_d),
        .pix_data     (pix_data),
        .line_active  (line_active),
        .frame_active (frame_active),
        .frame_start  (frame_start),
        .stat_sample  (stat_sample)
    );

    // ====================
    // Capture sequencing
    // ====================
    capture_sequencer u_sequencer (
        .clk           (clk),
        .readout_rst   (readout_rst),
        .capture_start (capture_start),
        .skip_count    (skip_count),
        .header        (header),
        .pix_data      (pix_data),
        .line_active   (line_active),
        .frame_active  (frame_active),
        .frame_start   (frame_start),
        .capture_begin (capture_begin),
        .capture_frame (capture_frame),
        .capture_end   (capture_end),
        .word_valid    (word_valid),
        .word_data     (word_data)
    );

    // ====================
    // Statistics
    // ====================
    capture_stats u_stats (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .capture_begin   (capture_begin),
        .capture_frame   (capture_frame),
        .capture_end     (capture_end),
        .word_valid      (word_valid),
        .stat_sample     (stat_sample),
        .pix_data        (pix_data),
        .word_count      (word_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count),
        .capture_done    (capture_done)
    );

endmodule

// File: capture_stats.sv
`include "img_cfg.svh"

module capture_stats (
    input  logic                 clk,
    input  logic                 readout_rst,
    input  logic                 capture_begin,
    input  logic                 capture_frame,
    input  logic                 capture_end,
    input  logic                 word_valid,
    input  logic                 stat_sample,
    input  img_pkg::pixel_t      pix_data,
    output img_pkg::word_count_t word_count,
    output img_pkg::stat_count_t highlight_count,
    output img_pkg::stat_count_t shadow_count,
    output logic                 capture_done
);
    logic [`IMG_STAT_TOP_BITS-1:0] pix_top;
    logic                          is_highlight;
    logic                          is_shadow;

    // Classify sampled pixels by their top bits
    assign pix_top      = pix_data[`IMG_PIXEL_WIDTH-1 -: `IMG_STAT_TOP_BITS];
    assign is_highlight = capture_frame && stat_sample && (pix_top == '1);
    assign is_shadow    = capture_frame && stat_sample && (pix_top == '0);

    // ====================
    // Counters
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            word_count      <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (capture_begin) begin
            word_count      <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            if (word_valid) begin
                word_count <= word_count + 1'b1;
            end
            if (is_highlight) begin
                highlight_count <= highlight_count + 1'b1;
            end
            if (is_shadow) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

    // Done lands with the final word count
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            capture_done <= 1'b0;
        end else begin
            capture_done <= capture_end;
        end
    end

endmodule

// File: capture_sequencer.sv
`include "img_cfg.svh"

module capture_sequencer (
    input  logic               clk,
    input  logic               readout_rst,
    input  logic               capture_start,
    input  img_pkg::skip_t     skip_count,
    input  img_pkg::header_t   header,
    input  img_pkg::pixel_t    pix_data,
    input  logic               line_active,
    input  logic               frame_active,
    input  logic               frame_start,
    output logic               capture_begin,
    output logic               capture_frame,
    output logic               capture_end,
    output logic               word_valid,
    output img_pkg::img_word_t word_data
);
    import img_pkg::*;

    localparam int HDR_CNT_W = $clog2(`IMG_HEADER_WORDS);

    capture_state_t         state;
    header_t                hdr_shift;
    logic [HDR_CNT_W-1:0]   hdr_left;
    skip_t                  skip_left;
    logic                   sum_clear;
    logic                   sum_enable;
    checksum_t              sum_value;
    img_word_t              pix_word;

    // Checksum follows the registered output words
    fletcher_checksum u_checksum (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (sum_clear),
        .enable      (sum_enable),
        .data        (word_data),
        .checksum    (sum_value)
    );

    assign sum_clear     = (state == st_load);
    assign capture_begin = (state == st_load);
    assign capture_frame = (state == st_pixels);

    // Little-endian pixel word
    assign pix_word = {pix_data[7:0],
                       {(`IMG_WORD_WIDTH - `IMG_PIXEL_WIDTH){1'b0}},
                       pix_data[`IMG_PIXEL_WIDTH-1:8]};

    // ====================
    // Capture FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state       <= st_idle;
            hdr_left    <= '0;
            word_valid  <= 1'b0;
            sum_enable  <= 1'b0;
            capture_end <= 1'b0;
        end else begin
            word_valid  <= 1'b0;
            sum_enable  <= 1'b0;
            capture_end <= 1'b0;
            case (state)
                st_idle: begin
                    // Starts during a capture never reach this branch
                    if (capture_start) begin
                        state <= st_load;
                    end
                end
                st_load: begin
                    // First header word goes out here
                    word_valid <= 1'b1;
                    sum_enable <= 1'b1;
                    hdr_left   <= HDR_CNT_W'(`IMG_HEADER_WORDS - 2);
                    state      <= st_header;
                end
                st_header: begin
                    word_valid <= 1'b1;
                    sum_enable <= 1'b1;
                    hdr_left   <= hdr_left - 1'b1;
                    if (hdr_left == '0) begin
                        state <= st_wait_frame;
                    end
                end
                st_wait_frame: begin
                    if (frame_start) begin
                        state <= st_skip_check;
                    end
                end
                st_skip_check: begin
                    state <= (skip_left == '0) ? st_pixels : st_wait_frame;
                end
                st_pixels: begin
                    word_valid <= line_active;
                    sum_enable <= line_active;
                    if (!frame_active) begin
                        state <= st_checksum_lo;
                    end
                end
                st_checksum_lo: begin
                    word_valid <= 1'b1;
                    state      <= st_checksum_hi;
                end
                st_checksum_hi: begin
                    word_valid  <= 1'b1;
                    capture_end <= 1'b1;
                    state       <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Header, skip count and output word
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (capture_start) begin
                    hdr_shift <= header;
                    skip_left <= skip_count;
                end
            end
            st_load, st_header: begin
                word_data <= hdr_shift[$bits(header_t)-1 -: `IMG_WORD_WIDTH];
                hdr_shift <= hdr_shift << `IMG_WORD_WIDTH;
            end
            st_skip_check: begin
                if (skip_left != '0) begin
                    skip_left <= skip_left - 1'b1;
                end
            end
            st_pixels: begin
                word_data <= pix_word;
            end
            // Checksum halves are byte-swapped too
            st_checksum_lo: begin
                word_data <= {sum_value[7:0], sum_value[15:8]};
            end
            st_checksum_hi: begin
                word_data <= {sum_value[23:16], sum_value[31:24]};
            end
            default: begin
            end
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!readout_rst)
        !$isunknown(state) && state inside {st_idle, st_load, st_header, st_wait_frame,
                                            st_skip_check, st_pixels, st_checksum_lo,
                                            st_checksum_hi});

    a_no_word_from_idle: assert property (@(posedge clk) disable iff (!readout_rst)
        (state == st_idle) |-> !$rose(word_valid));

endmodule

// File: fletcher_checksum.sv
`include "img_cfg.svh"

module fletcher_checksum (
    input  logic               clk,
    input  logic               readout_rst,
    input  logic               clear,
    input  logic               enable,
    input  img_pkg::img_word_t data,
    output img_pkg::checksum_t checksum
);
    import img_pkg::*;

    img_word_t data_swap;
    img_word_t sum_lo;
    img_word_t sum_hi;
    img_word_t sum_lo_next;
    img_word_t sum_hi_next;

    // Addition modulo 65535 with end-around carry
    function automatic img_word_t add_mod(input img_word_t a, input img_word_t b);
        logic [`IMG_WORD_WIDTH:0] full;
        img_word_t                folded;
        full   = {1'b0, a} + {1'b0, b};
        folded = full[`IMG_WORD_WIDTH-1:0] + img_word_t'(full[`IMG_WORD_WIDTH]);
        return (folded == '1) ? '0 : folded;
    endfunction

    // Words are summed as little-endian
    assign data_swap   = {data[7:0], data[15:8]};
    assign sum_lo_next = add_mod(sum_lo, data_swap);
    assign sum_hi_next = add_mod(sum_hi, sum_lo_next);

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            sum_lo <= '0;
            sum_hi <= '0;
        end else if (enable) begin
            sum_lo <= sum_lo_next;
            sum_hi <= sum_hi_next;
        end
    end

    assign checksum = {sum_hi, sum_lo};

    a_clear_excludes_enable: assert property (@(posedge clk) disable iff (!readout_rst)
        !(clear && enable));

endmodule

// File: frame_timing.sv
`include "img_cfg.svh"

module frame_timing (
    input  logic            clk,
    input  logic            readout_rst,
    input  logic            img_fv,
    input  logic            img_lv,
    input  img_pkg::pixel_t img_d,
    output img_pkg::pixel_t pix_data,
    output logic            line_active,
    output logic            frame_active,
    output logic            frame_start,
    output logic            stat_sample
);
    logic                       fv_prev;
    logic                       lv_prev;
    logic [`IMG_GRID_BITS-1:0]  col_phase;
    logic [`IMG_GRID_BITS-1:0]  line_phase;

    // Pixel bus register
    always_ff @(posedge clk) begin
        pix_data <= img_d;
    end

    // ====================
    // Video strobes
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            frame_active <= 1'b0;
            line_active  <= 1'b0;
            fv_prev      <= 1'b0;
            lv_prev      <= 1'b0;
            frame_start  <= 1'b0;
        end else begin
            frame_active <= img_fv;
            line_active  <= img_lv;
            fv_prev      <= frame_active;
            lv_prev      <= line_active;
            frame_start  <= frame_active && !fv_prev;
        end
    end

    // Position within the 4x4 sample grid
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            col_phase  <= '0;
            line_phase <= '0;
        end else begin
            if (!line_active) begin
                col_phase <= '0;
            end else begin
                col_phase <= col_phase + 1'b1;
            end
            // Line phase steps on each line end
            if (!frame_active) begin
                line_phase <= '0;
            end else if (lv_prev && !line_active) begin
                line_phase <= line_phase + 1'b1;
            end
        end
    end

    assign stat_sample = line_active && (col_phase == '0) && (line_phase == '0);

    a_line_inside_frame: assert property (@(posedge clk) disable iff (!readout_rst)
        $rose(line_active) |-> frame_active);

endmodule

// File: img_pkg.sv
`include "img_cfg.svh"

package img_pkg;

    // ====================
    // Data widths
    // ====================
    typedef logic [`IMG_PIXEL_WIDTH-1:0]                    pixel_t;
    typedef logic [`IMG_WORD_WIDTH-1:0]                     img_word_t;
    // First header word sits in the top bits
    typedef logic [`IMG_HEADER_WORDS*`IMG_WORD_WIDTH-1:0]   header_t;
    typedef logic [2*`IMG_WORD_WIDTH-1:0]                   checksum_t;
    typedef logic [`IMG_STAT_WIDTH-1:0]                     stat_count_t;
    typedef logic [`IMG_COUNT_WIDTH-1:0]                    word_count_t;
    typedef logic [`IMG_SKIP_WIDTH-1:0]                     skip_t;

    // ====================
    // Capture FSM
    // ====================
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_header,
        st_wait_frame,
        st_skip_check,
        st_pixels,
        st_checksum_lo,
        st_checksum_hi
    } capture_state_t;

endpackage

// File: img_cfg.svh
`ifndef IMG_CFG_SVH
`define IMG_CFG_SVH

// ====================
// Capture format
// ====================
`define IMG_HEADER_WORDS    4
`define IMG_PIXEL_WIDTH     12
`define IMG_WORD_WIDTH      16

// ====================
// Statistics
// ====================
`define IMG_STAT_WIDTH      18
`define IMG_COUNT_WIDTH     16
// Top pixel bits that must be all ones or all zeros
`define IMG_STAT_TOP_BITS   7
`define IMG_SKIP_WIDTH      2
// Sample every 4th pixel of every 4th line
`define IMG_GRID_BITS       2

`endif
